/* logic/dcache_params.svh */
// geometry is fixed at two ways of two-word blocks; the widths must add up to a 32-bit address
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DCACHE_SETS 8
`define DCACHE_WORD_W 32

`define DCACHE_TAG_W 26
`define DCACHE_IDX_W 3
`define DCACHE_BLK_W 1

`endif

/* logic/dcache_pkg.sv */
// types assume word-aligned accesses; the byte offset is carried but never used for selection
`include "dcache_params.svh"

package dcache_pkg;

	typedef logic [`DCACHE_WORD_W-1:0] word_t;

	typedef struct packed {
		logic [`DCACHE_TAG_W-1:0] tag;
		logic [`DCACHE_IDX_W-1:0] idx;
		logic [`DCACHE_BLK_W-1:0] blkoff;
		logic [1:0] bytoff;
	} daddr_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [`DCACHE_TAG_W-1:0] tag;
		word_t word0;
		word_t word1;
	} dframe_t;

	typedef logic way_t;

	typedef enum logic [3:0] {
		IDLE, WEN_SNOOP, SNOOP, CC_WB0, CC_WB1, LD_SNOOP, LD0, LD1,
		WB0, WB1, CLEAN, FLUSH0, FLUSH1, HALTED
	} dstate_t;

endpackage

/* logic/dcache_if.sv */
// all returned values are combinational; writes land on the next clock edge
`timescale 1ns/1ps
`include "dcache_params.svh"

interface frame_port_if;
	dcache_pkg::daddr_t req_addr;
	dcache_pkg::daddr_t snoop_addr;
	logic [`DCACHE_IDX_W:0] frame_sel;  // {way, set}
	logic wr_en;
	dcache_pkg::dframe_t wr_frame;
	logic touch_en;
	dcache_pkg::way_t touch_way;  // way just used
	logic req_hit;
	dcache_pkg::way_t req_way;
	logic snoop_hit;
	dcache_pkg::way_t snoop_way;
	dcache_pkg::way_t victim_way;
	dcache_pkg::dframe_t rd_frame;
	dcache_pkg::dframe_t req_frame;

	modport master (
		output req_addr, snoop_addr, frame_sel, wr_en, wr_frame, touch_en, touch_way,
		input req_hit, req_way, snoop_hit, snoop_way, victim_way, rd_frame, req_frame
	);

	modport slave (
		input req_addr, snoop_addr, frame_sel, wr_en, wr_frame, touch_en, touch_way,
		output req_hit, req_way, snoop_hit, snoop_way, victim_way, rd_frame, req_frame
	);
endinterface

interface link_port_if;
	logic ll_set;
	logic kill;
	dcache_pkg::word_t kill_addr;
	dcache_pkg::word_t check_addr;
	logic sc_ok;

	modport master (output ll_set, kill, kill_addr, check_addr, input sc_ok);
	modport slave (input ll_set, kill, kill_addr, check_addr, output sc_ok);
endinterface

/* logic/dcache_ways.sv */
// a tag may match in at most one way of a set; tag and data arrays come up undefined
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ways (
	input logic CLK,
	input logic nRST,
	frame_port_if.slave fp
);
	logic [1:0][`DCACHE_SETS-1:0] valid_q;
	logic [1:0][`DCACHE_SETS-1:0] dirty_q;
	logic [`DCACHE_SETS-1:0] lru_q;  // victim way per set
	logic [`DCACHE_TAG_W-1:0] tag_q [2][`DCACHE_SETS];
	dcache_pkg::word_t word0_q [2][`DCACHE_SETS];
	dcache_pkg::word_t word1_q [2][`DCACHE_SETS];
	dcache_pkg::dframe_t frame [2][`DCACHE_SETS];

	logic [1:0] req_match;
	logic [1:0] snoop_match;
	dcache_pkg::way_t sel_way;
	logic [`DCACHE_IDX_W-1:0] sel_idx;

	assign sel_way = fp.frame_sel[`DCACHE_IDX_W];
	assign sel_idx = fp.frame_sel[`DCACHE_IDX_W-1:0];

	always_comb
	begin
		for (int w = 0; w < 2; w++)
		begin
			for (int s = 0; s < `DCACHE_SETS; s++)
			begin
				frame[w][s].valid = valid_q[w][s];
				frame[w][s].dirty = dirty_q[w][s];
				frame[w][s].tag = tag_q[w][s];
				frame[w][s].word0 = word0_q[w][s];
				frame[w][s].word1 = word1_q[w][s];
			end
		end
	end

	// request and snoop lookups run side by side
	always_comb
	begin
		for (int w = 0; w < 2; w++)
		begin
			req_match[w] = frame[w][fp.req_addr.idx].valid
				&& (frame[w][fp.req_addr.idx].tag == fp.req_addr.tag);
			snoop_match[w] = frame[w][fp.snoop_addr.idx].valid
				&& (frame[w][fp.snoop_addr.idx].tag == fp.snoop_addr.tag);
		end
	end

	assign fp.req_hit = |req_match;
	assign fp.req_way = req_match[1];
	assign fp.snoop_hit = |snoop_match;
	assign fp.snoop_way = snoop_match[1];
	assign fp.victim_way = lru_q[fp.req_addr.idx];
	assign fp.rd_frame = frame[sel_way][sel_idx];
	assign fp.req_frame = frame[fp.req_way][fp.req_addr.idx];

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end
		else
		begin
			if (fp.wr_en)
			begin
				valid_q[sel_way][sel_idx] <= fp.wr_frame.valid;
				dirty_q[sel_way][sel_idx] <= fp.wr_frame.dirty;
			end
			if (fp.touch_en)
				lru_q[sel_idx] <= ~fp.touch_way;  // other way goes next
		end
	end

	always_ff @(posedge CLK)
	begin
		if (fp.wr_en)
		begin
			tag_q[sel_way][sel_idx] <= fp.wr_frame.tag;
			word0_q[sel_way][sel_idx] <= fp.wr_frame.word0;
			word1_q[sel_way][sel_idx] <= fp.wr_frame.word1;
		end
	end

endmodule

/* logic/dcache_link.sv */
// links on the exact word address; a store to the other word of the block keeps the link
`timescale 1ns/1ps

module dcache_link (
	input logic CLK,
	input logic nRST,
	link_port_if.slave lp
);
	dcache_pkg::word_t link_addr_q;
	logic link_valid_q;

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
			link_valid_q <= 1'b0;
		else if (lp.ll_set)
			link_valid_q <= 1'b1;
		else if (lp.kill && (lp.kill_addr == link_addr_q))
			link_valid_q <= 1'b0;
	end

	always_ff @(posedge CLK)
	begin
		if (lp.ll_set)
			link_addr_q <= lp.check_addr;
	end

	assign lp.sc_ok = link_valid_q && (lp.check_addr == link_addr_q);

endmodule

/* logic/dcache_ctrl.sv */
// expects the processor and the bus to hold address and snoop address until each step completes
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ctrl (
	input logic CLK,
	input logic nRST,
	frame_port_if.master fp,
	link_port_if.master lp,
	input logic dmemren_i,
	input logic dmemwen_i,
	input logic datomic_i,
	input logic halt_i,
	input dcache_pkg::word_t dmemaddr_i,
	input dcache_pkg::word_t dmemstore_i,
	output logic dhit_o,
	output logic flushed_o,
	output dcache_pkg::word_t dmemload_o,
	output logic dren_o,
	output logic dwen_o,
	output logic cctrans_o,
	output logic ccwrite_o,
	output dcache_pkg::word_t daddr_o,
	output dcache_pkg::word_t dstore_o,
	input dcache_pkg::word_t dload_i,
	input logic dwait_i,
	input logic ccwait_i,
	input logic ccinv_i,
	input dcache_pkg::word_t ccsnoopaddr_i
);
	dcache_pkg::dstate_t state_q, state_d;
	logic [`DCACHE_IDX_W+1:0] flush_q, flush_d;  // {done, set, way}
	dcache_pkg::word_t ld_word_q;
	dcache_pkg::daddr_t req_a;
	dcache_pkg::daddr_t snp_a;
	dcache_pkg::dframe_t rd;
	dcache_pkg::dframe_t upd;
	logic ll, sc, sc_fail;
	logic [`DCACHE_IDX_W:0] req_sel;
	logic [`DCACHE_IDX_W:0] snp_sel;
	logic [`DCACHE_IDX_W:0] fl_sel;

	function automatic dcache_pkg::word_t blk_addr(
		input logic [`DCACHE_TAG_W-1:0] tag,
		input logic [`DCACHE_IDX_W-1:0] idx,
		input logic [`DCACHE_BLK_W-1:0] blk
	);
		dcache_pkg::daddr_t a;
		a.tag = tag;
		a.idx = idx;
		a.blkoff = blk;
		a.bytoff = '0;
		return a;
	endfunction

	assign req_a = dmemaddr_i;
	assign snp_a = ccsnoopaddr_i;
	assign rd = fp.rd_frame;
	assign ll = datomic_i & dmemren_i;
	assign sc = datomic_i & dmemwen_i;
	assign sc_fail = sc & ~lp.sc_ok;
	assign req_sel = {(fp.req_hit ? fp.req_way : fp.victim_way), req_a.idx};  // hit or victim
	assign snp_sel = {fp.snoop_way, snp_a.idx};
	assign fl_sel = {flush_q[0], flush_q[`DCACHE_IDX_W:1]};

	assign fp.req_addr = req_a;
	assign fp.snoop_addr = snp_a;
	assign fp.touch_way = fp.req_way;
	assign lp.check_addr = dmemaddr_i;
	assign lp.kill_addr = (state_q == dcache_pkg::SNOOP) ? ccsnoopaddr_i : dmemaddr_i;
	assign flushed_o = (state_q == dcache_pkg::HALTED);
	assign dmemload_o = sc ? dcache_pkg::word_t'(lp.sc_ok)
		: (req_a.blkoff ? fp.req_frame.word1 : fp.req_frame.word0);

	// store data merged into the selected frame
	always_comb
	begin
		upd = rd;
		upd.dirty = 1'b1;
		if (req_a.blkoff)
			upd.word1 = dmemstore_i;
		else
			upd.word0 = dmemstore_i;
	end

	always_comb
	begin
		state_d = state_q;
		flush_d = flush_q;
		fp.frame_sel = req_sel;
		fp.wr_en = 1'b0;
		fp.wr_frame = rd;
		fp.touch_en = 1'b0;
		lp.ll_set = 1'b0;
		lp.kill = 1'b0;
		dhit_o = 1'b0;
		dren_o = 1'b0;
		dwen_o = 1'b0;
		cctrans_o = 1'b0;
		ccwrite_o = 1'b0;
		daddr_o = '0;
		dstore_o = '0;
		case (state_q)
			dcache_pkg::IDLE:
			begin
				if (ccwait_i)
					state_d = dcache_pkg::SNOOP;  // snoops first
				else if (halt_i)
				begin
					state_d = dcache_pkg::CLEAN;
					flush_d = '0;
				end
				else if (dmemren_i | dmemwen_i)
				begin
					if (sc_fail)
						dhit_o = 1'b1;  // no write, returns 0
					else if (!fp.req_hit)
						state_d = rd.dirty ? dcache_pkg::WB0 : dcache_pkg::LD_SNOOP;
					else if (dmemren_i | rd.dirty)
					begin
						dhit_o = 1'b1;
						fp.touch_en = 1'b1;
						lp.ll_set = ll;
						fp.wr_en = dmemwen_i;
						fp.wr_frame = upd;
					end
					else
						state_d = dcache_pkg::WEN_SNOOP;  // clean block needs ownership
				end
			end
			dcache_pkg::WEN_SNOOP:
			begin
				cctrans_o = 1'b1;
				ccwrite_o = 1'b1;
				daddr_o = dmemaddr_i;
				if (ccwait_i & ccinv_i)
				begin
					state_d = dcache_pkg::IDLE;
					dhit_o = fp.req_hit;
					fp.touch_en = fp.req_hit;
					fp.wr_en = fp.req_hit;
					fp.wr_frame = upd;
				end
				else if (ccwait_i)
					state_d = dcache_pkg::SNOOP;
			end
			dcache_pkg::SNOOP:
			begin
				fp.frame_sel = snp_sel;
				cctrans_o = 1'b1;
				state_d = dcache_pkg::IDLE;
				lp.kill = ccinv_i | (fp.snoop_hit & rd.dirty);
				if (fp.snoop_hit)
				begin
					ccwrite_o = rd.dirty;  // we supply the block
					if (rd.dirty)
						state_d = dcache_pkg::CC_WB0;
					else if (ccinv_i)
					begin
						fp.wr_en = 1'b1;
						fp.wr_frame.valid = 1'b0;
					end
				end
			end
			dcache_pkg::CC_WB0:
			begin
				fp.frame_sel = snp_sel;
				dwen_o = 1'b1;
				daddr_o = blk_addr(rd.tag, snp_a.idx, 1'b0);
				dstore_o = rd.word0;
				if (!dwait_i)
					state_d = dcache_pkg::CC_WB1;
			end
			dcache_pkg::CC_WB1:
			begin
				fp.frame_sel = snp_sel;
				dwen_o = 1'b1;
				daddr_o = blk_addr(rd.tag, snp_a.idx, 1'b1);
				dstore_o = rd.word1;
				if (!dwait_i)
				begin
					state_d = dcache_pkg::IDLE;
					fp.wr_en = 1'b1;
					fp.wr_frame.valid = 1'b0;
					fp.wr_frame.dirty = 1'b0;
				end
			end
			dcache_pkg::WB0:
			begin
				dwen_o = 1'b1;
				daddr_o = blk_addr(rd.tag, req_a.idx, 1'b0);
				dstore_o = rd.word0;
				if (!dwait_i)
					state_d = dcache_pkg::WB1;
			end
			dcache_pkg::WB1:
			begin
				dwen_o = 1'b1;
				daddr_o = blk_addr(rd.tag, req_a.idx, 1'b1);
				dstore_o = rd.word1;
				if (!dwait_i)
				begin
					state_d = dcache_pkg::LD_SNOOP;
					fp.wr_en = 1'b1;
					fp.wr_frame.valid = 1'b0;
					fp.wr_frame.dirty = 1'b0;
				end
			end
			dcache_pkg::LD_SNOOP:
			begin
				cctrans_o = 1'b1;
				if (ccwait_i)
					state_d = ccinv_i ? dcache_pkg::LD0 : dcache_pkg::SNOOP;
			end
			dcache_pkg::LD0:
			begin
				dren_o = 1'b1;
				daddr_o = blk_addr(req_a.tag, req_a.idx, 1'b0);
				if (!dwait_i)
					state_d = dcache_pkg::LD1;
			end
			dcache_pkg::LD1:
			begin
				dren_o = 1'b1;
				daddr_o = blk_addr(req_a.tag, req_a.idx, 1'b1);
				if (!dwait_i)
				begin
					state_d = dcache_pkg::IDLE;  // request hits there
					fp.wr_en = 1'b1;
					fp.wr_frame = '{valid: 1'b1, dirty: 1'b0, tag: req_a.tag,
						word0: ld_word_q, word1: dload_i};
				end
			end
			dcache_pkg::CLEAN:
			begin
				fp.frame_sel = fl_sel;
				if (flush_q[`DCACHE_IDX_W+1])
					state_d = dcache_pkg::HALTED;
				else if (rd.dirty)
					state_d = dcache_pkg::FLUSH0;
				else
					flush_d = flush_q + 1'b1;
			end
			dcache_pkg::FLUSH0:
			begin
				fp.frame_sel = fl_sel;
				dwen_o = 1'b1;
				daddr_o = blk_addr(rd.tag, flush_q[`DCACHE_IDX_W:1], 1'b0);
				dstore_o = rd.word0;
				if (!dwait_i)
					state_d = dcache_pkg::FLUSH1;
			end
			dcache_pkg::FLUSH1:
			begin
				fp.frame_sel = fl_sel;
				dwen_o = 1'b1;
				daddr_o = blk_addr(rd.tag, flush_q[`DCACHE_IDX_W:1], 1'b1);
				dstore_o = rd.word1;
				if (!dwait_i)
				begin
					state_d = dcache_pkg::CLEAN;
					flush_d = flush_q + 1'b1;
					fp.wr_en = 1'b1;
					fp.wr_frame.dirty = 1'b0;
				end
			end
			dcache_pkg::HALTED:
			begin
				// everything is clean now, snoops only invalidate
				fp.frame_sel = snp_sel;
				cctrans_o = ccwait_i;
				if (ccwait_i & ccinv_i & fp.snoop_hit)
				begin
					fp.wr_en = 1'b1;
					fp.wr_frame.valid = 1'b0;
				end
			end
			default: state_d = dcache_pkg::IDLE;
		endcase
		if (dhit_o && dmemwen_i)
			lp.kill = 1'b1;
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state_q <= dcache_pkg::IDLE;
			flush_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			flush_q <= flush_d;
		end
	end

	always_ff @(posedge CLK)
	begin
		if ((state_q == dcache_pkg::LD0) && !dwait_i)
			ld_word_q <= dload_i;  // first refill word
	end

endmodule

/* logic/dcache_top.sv */
// one core's data cache; the arbiter, memory and the other cache sit outside
`timescale 1ns/1ps

module dcache_top (
	input logic CLK,
	input logic nRST,
	input logic dmemren_i,
	input logic dmemwen_i,
	input logic datomic_i,
	input logic halt_i,
	input dcache_pkg::word_t dmemaddr_i,
	input dcache_pkg::word_t dmemstore_i,
	output logic dhit_o,
	output dcache_pkg::word_t dmemload_o,
	output logic flushed_o,
	output logic dren_o,
	output logic dwen_o,
	output dcache_pkg::word_t daddr_o,
	output dcache_pkg::word_t dstore_o,
	input dcache_pkg::word_t dload_i,
	input logic dwait_i,
	output logic cctrans_o,
	output logic ccwrite_o,
	input logic ccwait_i,
	input logic ccinv_i,
	input dcache_pkg::word_t ccsnoopaddr_i
);
	frame_port_if fp ();
	link_port_if lp ();

	dcache_ctrl i_ctrl (
		.fp (fp),
		.lp (lp),
		.*
	);

	dcache_ways i_ways (
		.CLK (CLK),
		.nRST (nRST),
		.fp (fp)
	);

	dcache_link i_link (
		.CLK (CLK),
		.nRST (nRST),
		.lp (lp)
	);

endmodule

/* verification/dcache_props.sv */
// checks only the memory strobes and the flush flag; disabled during reset
`timescale 1ns/1ps

module dcache_props (
	input logic CLK,
	input logic nRST,
	input logic dren_o,
	input logic dwen_o,
	input logic dwait_i,
	input logic flushed_o,
	input dcache_pkg::word_t daddr_o
);

	a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
		!(dren_o && dwen_o))
		else $error("dren_o and dwen_o high together");

	// a stalled write keeps its address
	a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
		(dwen_o && dwait_i) |=> (daddr_o == $past(daddr_o)))
		else $error("daddr_o moved during a stalled write");

	a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		flushed_o |=> flushed_o)
		else $error("flushed_o dropped");

endmodule

bind dcache_top dcache_props i_props (.*);

/* verification/dcache_tb.sv */
// uses word addresses below 256 only; memory and coherence are behavioral models
`timescale 1ns/1ps

module dcache_tb;
	localparam int TMO = 400;  // cycles per wait

	logic CLK = 1'b0;
	logic nRST;
	logic dmemren_i, dmemwen_i, datomic_i, halt_i;
	dcache_pkg::word_t dmemaddr_i, dmemstore_i, dmemload_o;
	logic dhit_o, flushed_o, dren_o, dwen_o, cctrans_o, ccwrite_o;
	dcache_pkg::word_t daddr_o, dstore_o, dload_i;
	logic dwait_i = 1'b1;
	logic ccwait_i = 1'b0;
	logic ccinv_i = 1'b0;
	dcache_pkg::word_t ccsnoopaddr_i = '0;

	dcache_pkg::word_t mem [64];
	dcache_pkg::word_t refm [64];  // what the processor should see
	integer seed = 80;
	int errors = 0;
	int checks = 0;
	int wr_cnt = 0;
	int dren_cnt = 0;
	int ccwrite_cnt = 0;
	logic snoop_req = 1'b0;
	logic snoop_seen = 1'b0;
	logic snoop_inv;
	dcache_pkg::word_t snoop_addr = '0;
	int grant_delay = 0;
	int e0;

	dcache_top i_dut (.*);

	always #20 CLK = ~CLK;

	function automatic dcache_pkg::word_t fill_word(input int i);
		return 32'h5a00_0000 ^ (i * 32'h0101_0107) ^ (i << 20);
	endfunction

	// memory model: takes or returns a word when dwait_i is low
	assign dload_i = mem[daddr_o[7:2]];

	always @(posedge CLK)
	begin
		if (!nRST)
		begin
			for (int i = 0; i < 64; i++)
				mem[i] <= fill_word(i);
		end
		else
		begin
			if (dwen_o && !dwait_i)
			begin
				mem[daddr_o[7:2]] <= dstore_o;
				wr_cnt <= wr_cnt + 1;
			end
			if (dren_o)
				dren_cnt <= dren_cnt + 1;
			if (cctrans_o && ccwrite_o)
				ccwrite_cnt <= ccwrite_cnt + 1;
		end
	end

	// memory stalls and the coherence controller
	always @(posedge CLK)
	begin
		#1;
		dwait_i = $random(seed) & 1;
		if (ccwait_i)
			ccwait_i = 1'b0;
		else if (snoop_req != snoop_seen)
		begin
			snoop_seen = snoop_req;
			ccsnoopaddr_i = snoop_addr;
			ccwait_i = 1'b1;
			ccinv_i = snoop_inv;
		end
		else if (cctrans_o)
		begin
			if (grant_delay == 0)
			begin
				ccwait_i = 1'b1;
				ccinv_i = 1'b1;  // grants always invalidate the other copy
				grant_delay = $random(seed) & 3;
			end
			else
				grant_delay = grant_delay - 1;
		end
	end

	task automatic check_word(input dcache_pkg::word_t act, input dcache_pkg::word_t exp,
		input string name);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, act, exp);
		end
	endtask

	task automatic check_bit(input logic act, input logic exp, input string name);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Fail %0t %s got %b expected %b", $time, name, act, exp);
		end
	endtask

	task automatic timeout_note(input string what);
		errors++;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	task automatic access(input logic ren, input logic wen, input logic atom,
		input dcache_pkg::word_t a, input dcache_pkg::word_t d, output dcache_pkg::word_t rd);
		int n;
		@(posedge CLK);
		#1;
		dmemren_i = ren;
		dmemwen_i = wen;
		datomic_i = atom;
		dmemaddr_i = a;
		dmemstore_i = d;
		n = 0;
		@(negedge CLK);
		while (!dhit_o && n < TMO)
		begin
			@(negedge CLK);
			n++;
		end
		if (!dhit_o)
			timeout_note("dhit_o");
		rd = dmemload_o;
		@(posedge CLK);
		#1;
		dmemren_i = 1'b0;
		dmemwen_i = 1'b0;
		datomic_i = 1'b0;
	endtask

	task automatic do_load(input dcache_pkg::word_t a);
		dcache_pkg::word_t rd;
		access(1'b1, 1'b0, 1'b0, a, '0, rd);
		check_word(rd, refm[a[7:2]], "dmemload_o");
	endtask

	task automatic do_ll(input dcache_pkg::word_t a);
		dcache_pkg::word_t rd;
		access(1'b1, 1'b0, 1'b1, a, '0, rd);
		check_word(rd, refm[a[7:2]], "dmemload_o");
	endtask

	task automatic do_store(input dcache_pkg::word_t a, input dcache_pkg::word_t d);
		dcache_pkg::word_t rd;
		access(1'b0, 1'b1, 1'b0, a, d, rd);
		refm[a[7:2]] = d;
	endtask

	task automatic do_sc(input dcache_pkg::word_t a, input dcache_pkg::word_t d,
		input logic ok);
		dcache_pkg::word_t rd;
		access(1'b0, 1'b1, 1'b1, a, d, rd);
		check_word(rd, dcache_pkg::word_t'(ok), "dmemload_o");
		if (ok)
			refm[a[7:2]] = d;
	endtask

	// cache must be idle; supplied tells whether it wrote the block back
	task automatic snoop(input dcache_pkg::word_t a, input logic inv, output logic supplied);
		int n;
		int w0;
		@(posedge CLK);
		snoop_addr = a;
		snoop_inv = inv;
		snoop_req = ~snoop_req;
		w0 = wr_cnt;
		@(posedge CLK);  // SNOOP entered here
		@(negedge CLK);
		supplied = ccwrite_o;
		if (supplied)
		begin
			n = 0;
			while (wr_cnt < w0 + 2 && n < TMO)
			begin
				@(negedge CLK);
				n++;
			end
			if (wr_cnt < w0 + 2)
				timeout_note("snoop write-back");
		end
		else
			@(posedge CLK);
	endtask

	function automatic dcache_pkg::word_t pick_addr();
		int i;
		i = {$random(seed)} % 12;
		return ((i % 6) / 2 << 6) | ((i < 6 ? 1 : 2) << 3) | ((i % 2) << 2);  // tag, set, word
	endfunction

	task automatic report(input int num, input string what);
		$display("behavior %0d %s: %s", num, what, (errors == e0) ? "ok" : "mismatch");
		e0 = errors;
	endtask

	initial
	begin
		dcache_pkg::word_t a;
		logic sup;
		int c0;
		nRST = 1'b0;
		dmemren_i = 1'b0;
		dmemwen_i = 1'b0;
		datomic_i = 1'b0;
		halt_i = 1'b0;
		dmemaddr_i = '0;
		dmemstore_i = '0;
		snoop_inv = 1'b0;
		e0 = 0;
		for (int i = 0; i < 64; i++)
			refm[i] = fill_word(i);
		repeat (10) @(posedge CLK);
		#1 nRST = 1'b1;

		for (int k = 0; k < 40; k++)
			do_load(pick_addr());
		report(1, "random loads");

		for (int k = 0; k < 60; k++)
		begin
			a = pick_addr();
			if ($random(seed) & 1)
				do_store(a, $random(seed));
			else
				do_load(a);
		end
		do_load(32'h28);
		c0 = ccwrite_cnt;
		do_store(32'h28, $random(seed));
		check_bit(ccwrite_cnt != c0, 1'b1, "ccwrite_o");
		do_load(32'h68);
		do_load(32'ha8);  // evicts the dirty block at 0x28
		check_word(mem[10], refm[10], "mem[0x28]");
		report(2, "random stores and eviction");

		do_store(32'h68, $random(seed));
		snoop(32'h68, 1'b0, sup);
		check_bit(sup, 1'b1, "ccwrite_o");
		check_word(mem[26], refm[26], "mem[0x68]");
		check_word(mem[27], refm[27], "mem[0x6c]");
		do_load(32'ha8);
		snoop(32'ha8, 1'b1, sup);
		c0 = dren_cnt;
		do_load(32'ha8);
		check_bit(dren_cnt != c0, 1'b1, "dren_o");
		report(3, "snoops");

		do_ll(32'h28);
		do_sc(32'h28, $random(seed), 1'b1);
		do_load(32'h28);
		do_ll(32'h28);
		do_store(32'h28, $random(seed));
		do_sc(32'h28, $random(seed), 1'b0);
		do_ll(32'h28);
		snoop(32'h28, 1'b1, sup);
		do_sc(32'h28, $random(seed), 1'b0);
		do_ll(32'h28);
		do_sc(32'h68, $random(seed), 1'b0);
		do_load(32'h28);
		do_load(32'h68);
		report(4, "load-linked and store-conditional");

		@(posedge CLK);
		#1 halt_i = 1'b1;
		c0 = 0;
		@(negedge CLK);
		while (!flushed_o && c0 < TMO)
		begin
			@(negedge CLK);
			c0++;
		end
		if (!flushed_o)
			timeout_note("flushed_o");
		repeat (4) @(negedge CLK);
		check_bit(flushed_o, 1'b1, "flushed_o");  // stays high once halted
		for (int i = 0; i < 64; i++)
			check_word(mem[i], refm[i], $sformatf("mem[%0d]", i));
		report(5, "halt and flush");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_if.sv
logic/dcache_ways.sv
logic/dcache_link.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verification/dcache_props.sv
verification/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module dcache_tb -o dcache_sim \
	&& ./obj_dir/dcache_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
	&& echo "simulation ok" \
	|| { echo "simulation reported failure or did not build"; exit 1; }
